/* daq_reg_pkg.sv */
package daq_reg_pkg;

  localparam int REG_DATA_W = 16;
  localparam int REG_ADDR_W = 8;
  localparam int MOD_ADDR_W = 6;
  localparam int CMD_W      = 32;

  // Command word layout, answers reuse it
  localparam int CMD_WR_BIT  = 31;
  localparam int CMD_MOD_HI  = 29;
  localparam int CMD_MOD_LO  = 24;
  localparam int CMD_REG_HI  = 23;
  localparam int CMD_REG_LO  = 16;
  localparam int CMD_DATA_HI = 15;

  localparam logic [MOD_ADDR_W-1:0] MODADDR_ID     = 6'h01;
  localparam logic [MOD_ADDR_W-1:0] MODADDR_TRG    = 6'h05;
  localparam logic [MOD_ADDR_W-1:0] MODADDR_TRGSEQ = 6'h06;
  localparam logic [MOD_ADDR_W-1:0] MODADDR_TRGMON = 6'h07;

  localparam logic [REG_DATA_W-1:0] BAD_READ = 16'h2BAD; // unknown module
  localparam logic [REG_DATA_W-1:0] FW_ID    = 16'hDA01;

endpackage

/* daq_trg_pkg.sv */
package daq_trg_pkg;

  // board_cfg
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] BRDADDR    = 8'd0;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] VERSION    = 8'd1;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] FWID       = 8'd2;
  // trg_seq
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] SEQ_COUNT  = 8'd0;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] SEQ_PERIOD = 8'd1;
  // trg_ctrl
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] TRG_CTRL   = 8'd0;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] TRG_BSYLEN = 8'd1;
  // trg_mon
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] MON_REQ_LO = 8'd0;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] MON_REQ_HI = 8'd1;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] MON_ACC_LO = 8'd2;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] MON_ACC_HI = 8'd3;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] MON_BSY_LO = 8'd4;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] MON_BSY_HI = 8'd5;
  localparam logic [daq_reg_pkg::REG_ADDR_W-1:0] MON_CLEAR  = 8'd8;

  localparam logic [daq_reg_pkg::REG_DATA_W-1:0] VERSION_RST    = 16'd2;
  localparam logic [daq_reg_pkg::REG_DATA_W-1:0] SEQ_PERIOD_RST = 16'd100;
  localparam logic [daq_reg_pkg::REG_DATA_W-1:0] BSYLEN_RST     = 16'd4;
  localparam logic [daq_reg_pkg::REG_DATA_W-1:0] SEQ_PERIOD_MIN = 16'd2;
  localparam logic [daq_reg_pkg::REG_DATA_W-1:0] BSYLEN_MIN     = 16'd1;

endpackage

/* reg_bus_master.sv */
`timescale 1ns/1ps

module reg_bus_master (
  input  logic                               clk40_i,
  input  logic                               arst_n_i,
  input  logic [daq_reg_pkg::CMD_W-1:0]      cmd_data_i,
  input  logic                               cmd_valid_i,
  output logic [daq_reg_pkg::CMD_W-1:0]      ans_data_o,
  output logic                               ans_valid_o,
  output logic [daq_reg_pkg::REG_ADDR_W-1:0] reg_addr_o,
  output logic [daq_reg_pkg::REG_DATA_W-1:0] reg_wdata_o,
  output logic                               id_we_o,
  output logic                               trg_we_o,
  output logic                               seq_we_o,
  output logic                               mon_we_o,
  input  logic [daq_reg_pkg::REG_DATA_W-1:0] id_rdata_i,
  input  logic [daq_reg_pkg::REG_DATA_W-1:0] trg_rdata_i,
  input  logic [daq_reg_pkg::REG_DATA_W-1:0] seq_rdata_i,
  input  logic [daq_reg_pkg::REG_DATA_W-1:0] mon_rdata_i
);
  import daq_reg_pkg::*;

  logic                  cmd_vld_q;
  logic                  cmd_wr_q;
  logic [MOD_ADDR_W-1:0] mod_addr_q;
  logic                  wr_stb;
  logic                  rd_stb;
  logic [REG_DATA_W-1:0] rd_mux;

  always_ff @(posedge clk40_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_vld_q   <= 1'b0;
      cmd_wr_q    <= 1'b0;
      ans_valid_o <= 1'b0;
    end else begin
      cmd_vld_q   <= cmd_valid_i;
      cmd_wr_q    <= cmd_data_i[CMD_WR_BIT];
      ans_valid_o <= rd_stb;
    end
  end

  // Command fields, one stage
  always_ff @(posedge clk40_i) begin
    if (cmd_valid_i) begin
      mod_addr_q  <= cmd_data_i[CMD_MOD_HI:CMD_MOD_LO];
      reg_addr_o  <= cmd_data_i[CMD_REG_HI:CMD_REG_LO];
      reg_wdata_o <= cmd_data_i[CMD_DATA_HI:0];
    end
  end

  assign wr_stb   = cmd_vld_q & cmd_wr_q;
  assign rd_stb   = cmd_vld_q & ~cmd_wr_q;
  assign id_we_o  = wr_stb && (mod_addr_q == MODADDR_ID);
  assign trg_we_o = wr_stb && (mod_addr_q == MODADDR_TRG);
  assign seq_we_o = wr_stb && (mod_addr_q == MODADDR_TRGSEQ);
  assign mon_we_o = wr_stb && (mod_addr_q == MODADDR_TRGMON);

  always_comb begin
    case (mod_addr_q)
      MODADDR_ID:     rd_mux = id_rdata_i;
      MODADDR_TRG:    rd_mux = trg_rdata_i;
      MODADDR_TRGSEQ: rd_mux = seq_rdata_i;
      MODADDR_TRGMON: rd_mux = mon_rdata_i;
      default:        rd_mux = BAD_READ;
    endcase
  end

  // Flag bits cleared, address fields echoed
  always_ff @(posedge clk40_i) begin
    if (rd_stb) ans_data_o <= {2'b00, mod_addr_q, reg_addr_o, rd_mux};
  end

  a_we_onehot: assert property (@(posedge clk40_i) disable iff (!arst_n_i)
    $onehot0({id_we_o, trg_we_o, seq_we_o, mon_we_o}));

endmodule

/* board_cfg.sv */
`timescale 1ns/1ps

module board_cfg (
  input  logic                               clk40_i,
  input  logic                               arst_n_i,
  input  logic                               we_i,
  input  logic [daq_reg_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [daq_reg_pkg::REG_DATA_W-1:0] reg_wdata_i,
  output logic [daq_reg_pkg::REG_DATA_W-1:0] rdata_o,
  input  logic [3:0]                         brdaddr_i,
  input  logic                               r21_i,
  input  logic                               p22_i,
  input  logic                               u21_i,
  output logic                               r22_o,
  output logic                               u21_o,
  output logic                               u21_oe_o,
  output logic                               u22_o,
  output logic                               u22_oe_o,
  output logic                               ext_trg_o,
  output logic                               ext_bsy_o,
  input  logic                               trg_out_i,
  input  logic                               bsy_out_i
);
  import daq_reg_pkg::*;
  import daq_trg_pkg::*;

  logic [REG_DATA_W-1:0] version_q;

  always_ff @(posedge clk40_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      version_q <= VERSION_RST;
    end else if (we_i && reg_addr_i == VERSION) begin
      version_q <= reg_wdata_i;
    end
  end

  always_comb begin
    case (reg_addr_i)
      BRDADDR: rdata_o = {{(REG_DATA_W-4){1'b0}}, brdaddr_i};
      VERSION: rdata_o = version_q;
      FWID:    rdata_o = FW_ID;
      default: rdata_o = '0;
    endcase
  end

  // LEMO assignment differs per board revision
  always_comb begin
    ext_trg_o = 1'b0;
    ext_bsy_o = 1'b1; // Unknown board holds busy
    r22_o     = 1'b0;
    u21_o     = 1'b0;
    u21_oe_o  = 1'b0;
    u22_o     = 1'b0;
    u22_oe_o  = 1'b0;
    case (version_q)
      16'd2: begin
        ext_trg_o = r21_i;
        ext_bsy_o = p22_i;
        r22_o     = trg_out_i;
        u21_o     = bsy_out_i;
        u21_oe_o  = 1'b1;
      end
      16'd3: begin
        ext_trg_o = r21_i;
        ext_bsy_o = u21_i; // u21 turns into an input
        r22_o     = trg_out_i;
        u22_o     = bsy_out_i;
        u22_oe_o  = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* trg_seq.sv */
`timescale 1ns/1ps

module trg_seq (
  input  logic                               clk40_i,
  input  logic                               arst_n_i,
  input  logic                               we_i,
  input  logic [daq_reg_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [daq_reg_pkg::REG_DATA_W-1:0] reg_wdata_i,
  output logic [daq_reg_pkg::REG_DATA_W-1:0] rdata_o,
  output logic                               soft_trg_o
);
  import daq_reg_pkg::*;
  import daq_trg_pkg::*;

  logic [REG_DATA_W-1:0] period_q;  // programmed
  logic [REG_DATA_W-1:0] per_use_q; // latched at start
  logic [REG_DATA_W-1:0] count_q;
  logic [REG_DATA_W-1:0] timer_q;
  logic                  fire;

  assign fire       = (count_q != '0) && (timer_q == '0);
  assign soft_trg_o = fire;

  always_ff @(posedge clk40_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      period_q  <= SEQ_PERIOD_RST;
      per_use_q <= SEQ_PERIOD_RST;
      count_q   <= '0;
      timer_q   <= '0;
    end else begin
      if (we_i && reg_addr_i == SEQ_PERIOD) begin
        period_q <= (reg_wdata_i < SEQ_PERIOD_MIN) ? SEQ_PERIOD_MIN : reg_wdata_i;
      end
      if (we_i && reg_addr_i == SEQ_COUNT) begin
        count_q   <= reg_wdata_i; // Restart
        per_use_q <= period_q;
        timer_q   <= period_q - 1'b1;
      end else if (fire) begin
        count_q <= count_q - 1'b1;
        timer_q <= per_use_q - 1'b1;
      end else if (timer_q != '0) begin
        timer_q <= timer_q - 1'b1;
      end
    end
  end

  always_comb begin
    case (reg_addr_i)
      SEQ_COUNT:  rdata_o = count_q;
      SEQ_PERIOD: rdata_o = period_q;
      default:    rdata_o = '0;
    endcase
  end

  a_period_min: assert property (@(posedge clk40_i) disable iff (!arst_n_i)
    per_use_q >= SEQ_PERIOD_MIN);

endmodule

/* trg_ctrl.sv */
`timescale 1ns/1ps

module trg_ctrl (
  input  logic                               clk40_i,
  input  logic                               arst_n_i,
  input  logic                               we_i,
  input  logic [daq_reg_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [daq_reg_pkg::REG_DATA_W-1:0] reg_wdata_i,
  output logic [daq_reg_pkg::REG_DATA_W-1:0] rdata_o,
  input  logic                               soft_trg_i,
  input  logic                               ext_trg_i,
  input  logic                               ext_bsy_i,
  output logic                               trg_out_o,
  output logic                               bsy_out_o,
  output logic                               trg_req_o,
  output logic                               trg_acc_o,
  output logic                               bsy_o
);
  import daq_reg_pkg::*;
  import daq_trg_pkg::*;

  logic                  ext_en_q;
  logic                  force_q;
  logic [REG_DATA_W-1:0] bsylen_q;
  logic [REG_DATA_W-1:0] dead_q;
  logic [2:0]            trg_sync_q; // two sync flops plus edge history
  logic [1:0]            bsy_sync_q;
  logic                  acc_q;
  logic                  ext_edge;
  logic                  req;
  logic                  busy;

  assign ext_edge = ext_en_q & trg_sync_q[1] & ~trg_sync_q[2];
  assign req      = soft_trg_i | ext_edge;
  assign busy     = bsy_sync_q[1] | force_q | (dead_q != '0);

  always_ff @(posedge clk40_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ext_en_q   <= 1'b0;
      force_q    <= 1'b0;
      bsylen_q   <= BSYLEN_RST;
      dead_q     <= '0;
      trg_sync_q <= '0;
      bsy_sync_q <= '0;
      acc_q      <= 1'b0;
    end else begin
      trg_sync_q <= {trg_sync_q[1:0], ext_trg_i};
      bsy_sync_q <= {bsy_sync_q[0], ext_bsy_i};
      if (we_i && reg_addr_i == TRG_CTRL) begin
        ext_en_q <= reg_wdata_i[0];
        force_q  <= reg_wdata_i[1];
      end
      if (we_i && reg_addr_i == TRG_BSYLEN) begin
        bsylen_q <= (reg_wdata_i < BSYLEN_MIN) ? BSYLEN_MIN : reg_wdata_i;
      end
      acc_q <= req & ~busy;
      if (req && !busy) dead_q <= bsylen_q; // Dead time from the accept
      else if (dead_q != '0) dead_q <= dead_q - 1'b1;
    end
  end

  always_comb begin
    case (reg_addr_i)
      TRG_CTRL:   rdata_o = {{(REG_DATA_W-2){1'b0}}, force_q, ext_en_q};
      TRG_BSYLEN: rdata_o = bsylen_q;
      default:    rdata_o = '0;
    endcase
  end

  assign trg_req_o = req;
  assign trg_acc_o = acc_q;
  assign trg_out_o = acc_q;
  assign bsy_o     = busy;
  assign bsy_out_o = busy;

  a_no_acc_busy: assert property (@(posedge clk40_i) disable iff (!arst_n_i)
    trg_acc_o |-> $past(!bsy_o));

endmodule

/* trg_mon.sv */
`timescale 1ns/1ps

module trg_mon #(
  parameter int CNT_W = 32
) (
  input  logic                               clk40_i,
  input  logic                               arst_n_i,
  input  logic                               we_i,
  input  logic [daq_reg_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [daq_reg_pkg::REG_DATA_W-1:0] reg_wdata_i,
  output logic [daq_reg_pkg::REG_DATA_W-1:0] rdata_o,
  input  logic                               trg_req_i,
  input  logic                               trg_acc_i,
  input  logic                               bsy_i
);
  import daq_reg_pkg::*;
  import daq_trg_pkg::*;

  logic [CNT_W-1:0] req_cnt;
  logic [CNT_W-1:0] acc_cnt;
  logic [CNT_W-1:0] bsy_cnt;
  logic             clr;

  // Saturating increment
  function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt, input logic en);
    logic [CNT_W-1:0] nxt;
    nxt = cnt;
    if (en && cnt != '1) nxt = cnt + 1'b1;
    return nxt;
  endfunction

  function automatic logic [REG_DATA_W-1:0] hi_half(input logic [CNT_W-1:0] cnt);
    logic [CNT_W-1:0] shifted;
    shifted = cnt >> REG_DATA_W; // zero padded above CNT_W
    return shifted[REG_DATA_W-1:0];
  endfunction

  // Write data is ignored on clear
  assign clr = we_i && reg_addr_i == MON_CLEAR;

  always_ff @(posedge clk40_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_cnt <= '0;
      acc_cnt <= '0;
      bsy_cnt <= '0;
    end else if (clr) begin
      req_cnt <= '0;
      acc_cnt <= '0;
      bsy_cnt <= '0;
    end else begin
      req_cnt <= sat_inc(req_cnt, trg_req_i);
      acc_cnt <= sat_inc(acc_cnt, trg_acc_i);
      bsy_cnt <= sat_inc(bsy_cnt, bsy_i);
    end
  end

  always_comb begin
    case (reg_addr_i)
      MON_REQ_LO: rdata_o = req_cnt[REG_DATA_W-1:0];
      MON_REQ_HI: rdata_o = hi_half(req_cnt);
      MON_ACC_LO: rdata_o = acc_cnt[REG_DATA_W-1:0];
      MON_ACC_HI: rdata_o = hi_half(acc_cnt);
      MON_BSY_LO: rdata_o = bsy_cnt[REG_DATA_W-1:0];
      MON_BSY_HI: rdata_o = hi_half(bsy_cnt);
      default:    rdata_o = '0;
    endcase
  end

endmodule

/* daq_top.sv */
`timescale 1ns/1ps

module daq_top #(
  parameter int CNT_W = 32
) (
  input  logic                          clk40_i,
  input  logic                          arst_n_i,
  input  logic [daq_reg_pkg::CMD_W-1:0] cmd_data_i,
  input  logic                          cmd_valid_i,
  output logic [daq_reg_pkg::CMD_W-1:0] ans_data_o,
  output logic                          ans_valid_o,
  input  logic [3:0]                    brdaddr_i,
  input  logic                          r21_i,    // trigger in
  input  logic                          p22_i,    // busy in on v2
  input  logic                          u21_i,    // busy in on v3
  output logic                          r22_o,    // trigger out
  output logic                          u21_o,
  output logic                          u21_oe_o,
  output logic                          u22_o,
  output logic                          u22_oe_o
);
  import daq_reg_pkg::*;

  logic [REG_ADDR_W-1:0] reg_addr;
  logic [REG_DATA_W-1:0] reg_wdata;
  logic                  id_we, trg_we, seq_we, mon_we;
  logic [REG_DATA_W-1:0] id_rdata, trg_rdata, seq_rdata, mon_rdata;
  logic                  ext_trg, ext_bsy, trg_out, bsy_out;
  logic                  soft_trg, trg_req, trg_acc, bsy;

  reg_bus_master reg_bus_master_inst (
    .clk40_i, .arst_n_i, .cmd_data_i, .cmd_valid_i, .ans_data_o, .ans_valid_o,
    .reg_addr_o(reg_addr), .reg_wdata_o(reg_wdata),
    .id_we_o(id_we), .trg_we_o(trg_we), .seq_we_o(seq_we), .mon_we_o(mon_we),
    .id_rdata_i(id_rdata), .trg_rdata_i(trg_rdata),
    .seq_rdata_i(seq_rdata), .mon_rdata_i(mon_rdata)
  );

  board_cfg board_cfg_inst (
    .clk40_i, .arst_n_i, .we_i(id_we), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
    .rdata_o(id_rdata), .brdaddr_i, .r21_i, .p22_i, .u21_i,
    .r22_o, .u21_o, .u21_oe_o, .u22_o, .u22_oe_o,
    .ext_trg_o(ext_trg), .ext_bsy_o(ext_bsy), .trg_out_i(trg_out), .bsy_out_i(bsy_out)
  );

  trg_seq trg_seq_inst (
    .clk40_i, .arst_n_i, .we_i(seq_we), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
    .rdata_o(seq_rdata), .soft_trg_o(soft_trg)
  );

  trg_ctrl trg_ctrl_inst (
    .clk40_i, .arst_n_i, .we_i(trg_we), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
    .rdata_o(trg_rdata), .soft_trg_i(soft_trg), .ext_trg_i(ext_trg), .ext_bsy_i(ext_bsy),
    .trg_out_o(trg_out), .bsy_out_o(bsy_out),
    .trg_req_o(trg_req), .trg_acc_o(trg_acc), .bsy_o(bsy)
  );

  trg_mon #(
    .CNT_W(CNT_W)
  ) trg_mon_inst (
    .clk40_i, .arst_n_i, .we_i(mon_we), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
    .rdata_o(mon_rdata), .trg_req_i(trg_req), .trg_acc_i(trg_acc), .bsy_i(bsy)
  );

endmodule

/* tb_daq_top.sv */
`timescale 1ns/1ps

module tb_daq_top;
  import daq_reg_pkg::*;
  import daq_trg_pkg::*;

  localparam int CNT_W   = 32;
  localparam int TIMEOUT = 4000; // cycles

  logic                  clk40;
  logic                  arst_n;
  logic [CMD_W-1:0]      cmd_data;
  logic                  cmd_valid;
  logic [CMD_W-1:0]      ans_data;
  logic                  ans_valid;
  logic [3:0]            brdaddr;
  logic                  r21;
  logic                  p22;
  logic                  u21;
  logic                  r22;
  logic                  u21_out;
  logic                  u21_oe;
  logic                  u22_out;
  logic                  u22_oe;
  int                    cyc = 0;
  int                    r22_cnt = 0;
  logic [CMD_W-1:0]      exp_word_q[$];
  logic [CMD_W-1:0]      exp_mask_q[$];
  int                    exp_cyc_q[$];
  logic [REG_DATA_W-1:0] last_rdata;

  daq_top #(
    .CNT_W(CNT_W)
  ) daq_top_inst (
    .clk40_i(clk40), .arst_n_i(arst_n), .cmd_data_i(cmd_data), .cmd_valid_i(cmd_valid),
    .ans_data_o(ans_data), .ans_valid_o(ans_valid), .brdaddr_i(brdaddr),
    .r21_i(r21), .p22_i(p22), .u21_i(u21), .r22_o(r22), .u21_o(u21_out),
    .u21_oe_o(u21_oe), .u22_o(u22_out), .u22_oe_o(u22_oe)
  );

  initial begin
    clk40 = 1'b0;
    forever #5 clk40 = ~clk40;
  end

  always @(posedge clk40) begin
    cyc <= cyc + 1;
    if (arst_n && r22) r22_cnt <= r22_cnt + 1;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      report_error($sformatf("FAILED at %0t: %s, got %0h, expected %0h", $time, msg, got, exp));
    end
  endtask

  // Answers come back in order
  always @(posedge clk40) begin
    logic [CMD_W-1:0] mask;
    logic [CMD_W-1:0] word;
    if (arst_n) begin
      if (ans_valid) begin
        if (exp_word_q.size() == 0) report_error("An answer word arrived with no read pending");
        mask = exp_mask_q.pop_front();
        word = exp_word_q.pop_front();
        check_value(cyc, exp_cyc_q.pop_front(), "answer cycle after its read");
        check_value(ans_data & mask, word & mask, "answer word");
        last_rdata = ans_data[REG_DATA_W-1:0];
      end else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc) begin
        report_error("A read got no answer two cycles after it was sent");
      end
    end
  end

  // Accepts for a request every p cycles under the dead-time rule
  function automatic int expected_accepts(input int n, input int p, input int bsylen,
                                          input logic force_bsy);
    int acc;
    int last;
    acc  = 0;
    last = 0;
    if (force_bsy) return 0;
    for (int k = 0; k < n; k++) begin
      if (acc == 0 || k * p - last > bsylen) begin
        acc++;
        last = k * p;
      end
    end
    return acc;
  endfunction

  task automatic drive_cmd(input logic wr, input logic [MOD_ADDR_W-1:0] mod,
                           input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] data);
    @(negedge clk40);
    cmd_data  = {wr, 1'b0, mod, addr, data};
    cmd_valid = 1'b1;
  endtask

  task automatic bus_idle();
    @(negedge clk40);
    cmd_valid = 1'b0;
    cmd_data  = $urandom; // Junk while idle
  endtask

  task automatic issue_read(input logic [MOD_ADDR_W-1:0] mod, input logic [REG_ADDR_W-1:0] addr,
                            input logic [REG_DATA_W-1:0] exp, input logic chk);
    drive_cmd(1'b0, mod, addr, 16'($urandom));
    exp_word_q.push_back({2'b00, mod, addr, exp});
    exp_mask_q.push_back(chk ? 32'hFFFF_FFFF : 32'hFFFF_0000);
    exp_cyc_q.push_back(cyc + 2);
  endtask

  task automatic wait_answers();
    int n;
    n = 0;
    while (exp_cyc_q.size() != 0) begin
      @(negedge clk40);
      n++;
      if (n > TIMEOUT) report_error("Timeout while waiting for register answers");
    end
  endtask

  task automatic write_reg(input logic [MOD_ADDR_W-1:0] mod, input logic [REG_ADDR_W-1:0] addr,
                           input logic [REG_DATA_W-1:0] data);
    drive_cmd(1'b1, mod, addr, data);
    bus_idle();
  endtask

  task automatic read_check(input logic [MOD_ADDR_W-1:0] mod, input logic [REG_ADDR_W-1:0] addr,
                            input logic [REG_DATA_W-1:0] exp);
    issue_read(mod, addr, exp, 1'b1);
    bus_idle();
    wait_answers();
  endtask

  task automatic read_value(input logic [MOD_ADDR_W-1:0] mod, input logic [REG_ADDR_W-1:0] addr,
                            output logic [REG_DATA_W-1:0] val);
    issue_read(mod, addr, 16'h0000, 1'b0);
    bus_idle();
    wait_answers();
    val = last_rdata;
  endtask

  task automatic read_counter(input logic [REG_ADDR_W-1:0] lo_addr, output logic [31:0] val);
    logic [REG_DATA_W-1:0] lo;
    logic [REG_DATA_W-1:0] hi;
    read_value(MODADDR_TRGMON, lo_addr, lo);
    read_value(MODADDR_TRGMON, lo_addr + 8'd1, hi);
    val = {hi, lo};
  endtask

  // Polls the remaining count until the sequence is done
  task automatic run_sequence(input int n, input int p, output int pulses);
    int base;
    int guard;
    logic [REG_DATA_W-1:0] left;
    base  = r22_cnt;
    guard = 0;
    left  = 16'hFFFF;
    write_reg(MODADDR_TRGSEQ, SEQ_PERIOD, 16'(p));
    write_reg(MODADDR_TRGSEQ, SEQ_COUNT, 16'(n));
    while (left != 16'h0000) begin
      read_value(MODADDR_TRGSEQ, SEQ_COUNT, left);
      guard++;
      if (guard > TIMEOUT) report_error("Timeout while waiting for the trigger sequence to end");
    end
    pulses = r22_cnt - base;
  endtask

  task automatic wait_r22_count(input int target);
    int n;
    n = 0;
    while (r22_cnt < target) begin
      @(negedge clk40);
      n++;
      if (n > TIMEOUT) report_error("Timeout while waiting for a trigger pulse on r22");
    end
  endtask

  task automatic wait_busy_out(input logic lvl);
    int n;
    n = 0;
    while (u22_out !== lvl) begin
      @(negedge clk40);
      n++;
      if (n > TIMEOUT) report_error("Timeout while waiting for busy out on u22");
    end
  endtask

  task automatic pulse_r21();
    @(negedge clk40);
    r21 = 1'b1;
    repeat (3) @(negedge clk40);
    r21 = 1'b0;
    repeat (3) @(negedge clk40);
  endtask

  initial begin
    logic [REG_DATA_W-1:0] val;
    logic [31:0]           cnt;
    logic [MOD_ADDR_W-1:0] bad_mod;
    int                    n;
    int                    p;
    int                    bsylen;
    int                    pulses;
    int                    base;
    void'($urandom(32'h984397e0));
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd_data  = '0;
    brdaddr   = 4'($urandom);
    r21       = 1'b0;
    p22       = 1'b0;
    u21       = 1'b0;
    repeat (8) @(posedge clk40);
    @(negedge clk40);
    check_value(32'(r22), 0, "r22 in reset");
    check_value(32'(ans_valid), 0, "answer valid in reset");
    check_value(32'({u21_oe, u22_oe}), 2, "output enables in reset");
    arst_n = 1'b1;

    // Register access
    read_check(MODADDR_ID, BRDADDR, {12'h000, brdaddr});
    read_check(MODADDR_ID, FWID, 16'hDA01);
    read_check(MODADDR_ID, VERSION, 16'd2);
    val = 16'($urandom);
    write_reg(MODADDR_ID, VERSION, val);
    read_check(MODADDR_ID, VERSION, val);
    write_reg(MODADDR_ID, VERSION, 16'd2);
    write_reg(MODADDR_TRGSEQ, SEQ_PERIOD, 16'd1);
    read_check(MODADDR_TRGSEQ, SEQ_PERIOD, 16'd2); // clamped
    bad_mod = {3'b100, 3'($urandom)};
    issue_read(MODADDR_ID, FWID, 16'hDA01, 1'b1);
    issue_read(bad_mod, 8'($urandom), 16'h2BAD, 1'b1);
    issue_read(MODADDR_TRG, TRG_BSYLEN, 16'd4, 1'b1);
    issue_read(MODADDR_ID, BRDADDR, {12'h000, brdaddr}, 1'b1);
    bus_idle();
    wait_answers();

    // Spaced soft sequence
    bsylen = 1 + $urandom % 4;
    p      = bsylen + 1 + $urandom % 6;
    n      = 3 + $urandom % 5;
    write_reg(MODADDR_TRG, TRG_BSYLEN, 16'(bsylen));
    write_reg(MODADDR_TRGMON, MON_CLEAR, 16'($urandom));
    run_sequence(n, p, pulses);
    check_value(pulses, n, "r22 pulses, spaced sequence");
    read_counter(MON_REQ_LO, cnt);
    check_value(cnt, n, "request count, spaced sequence");
    read_counter(MON_ACC_LO, cnt);
    check_value(cnt, n, "accept count, spaced sequence");

    // Dead time rejects requests
    bsylen = 3 + $urandom % 5;
    p      = 2 + $urandom % (bsylen - 1);
    n      = 4 + $urandom % 6;
    write_reg(MODADDR_TRG, TRG_BSYLEN, 16'(bsylen));
    write_reg(MODADDR_TRGMON, MON_CLEAR, 16'($urandom));
    run_sequence(n, p, pulses);
    check_value(pulses, expected_accepts(n, p, bsylen, 1'b0), "r22 pulses, dense sequence");
    read_counter(MON_ACC_LO, cnt);
    check_value(cnt, expected_accepts(n, p, bsylen, 1'b0), "accept count, dense sequence");
    read_counter(MON_REQ_LO, cnt);
    check_value(cnt, n, "request count, dense sequence");

    // Forced busy
    write_reg(MODADDR_TRG, TRG_CTRL, 16'h0002);
    read_check(MODADDR_TRG, TRG_CTRL, 16'h0002);
    check_value(32'({u21_oe, u21_out}), 3, "busy out on u21");
    write_reg(MODADDR_TRGMON, MON_CLEAR, 16'($urandom));
    run_sequence(n, p, pulses);
    check_value(pulses, expected_accepts(n, p, bsylen, 1'b1), "r22 pulses, forced busy");
    read_counter(MON_ACC_LO, cnt);
    check_value(cnt, 0, "accept count, forced busy");
    read_counter(MON_BSY_LO, cnt);
    check_value(32'(cnt >= 32'(n * p)), 1, "busy count covers the sequence");
    write_reg(MODADDR_TRG, TRG_CTRL, 16'h0000);

    // Version 3 pins, external trigger and busy
    write_reg(MODADDR_ID, VERSION, 16'd3);
    read_check(MODADDR_ID, VERSION, 16'd3);
    check_value(32'({u21_oe, u22_oe}), 1, "output enables on version 3");
    write_reg(MODADDR_TRG, TRG_CTRL, 16'h0001);
    wait_busy_out(1'b0);
    base = r22_cnt;
    pulse_r21();
    wait_r22_count(base + 1);
    repeat (20) @(negedge clk40);
    check_value(r22_cnt - base, 1, "r22 pulses for one r21 edge");
    u21 = 1'b1;
    wait_busy_out(1'b1);
    repeat (3) pulse_r21();
    repeat (20) @(negedge clk40);
    check_value(r22_cnt - base, 1, "r22 pulses while u21 holds busy");
    u21 = 1'b0;

    // Counter clear
    write_reg(MODADDR_ID, VERSION, 16'd2);
    write_reg(MODADDR_TRG, TRG_CTRL, 16'h0000);
    read_check(MODADDR_TRG, TRG_CTRL, 16'h0000);
    write_reg(MODADDR_TRGMON, MON_CLEAR, 16'($urandom));
    for (int a = 0; a < 6; a++) begin
      read_check(MODADDR_TRGMON, 8'(a), 16'h0000);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

/* filelist.f */
daq_reg_pkg.sv
daq_trg_pkg.sv
reg_bus_master.sv
board_cfg.sv
trg_seq.sv
trg_ctrl.sv
trg_mon.sv
daq_top.sv
tb_daq_top.sv

/* Makefile */
# Verilator simulation of the DAQ control and trigger logic

VERILATOR ?= verilator
TOP       ?= tb_daq_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
